// File: Makefile
# Verilator build and run for the ADC acquisition testbench

VERILATOR ?= verilator
TOP       ?= adc_acq_mem_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
hdl/acq_pkg.sv
hdl/acq_trigger_ctrl.sv
hdl/acq_capture.sv
hdl/wave_store.sv
hdl/adc_acq_mem_top.sv
tb/adc_acq_mem_tb.sv

// File: hdl/acq_capture.sv
`timescale 1ns/1ps
`default_nettype none

module acq_capture #(
  parameter int PRE_DEPTH = 4096
) (
  input  wire                          clk125,
  input  wire                          rst_n,
  input  wire [acq_pkg::sample_w-1:0]  adc_dat,         // sampled on every edge
  input  wire                          adc_ovr,
  input  wire                          cap_start,       // one cycle pulse per fill
  input  wire acq_pkg::fill_cfg_t      cap_cfg,
  output logic                         cap_word_valid,
  output acq_pkg::mem_word_t           cap_word
);

  localparam int ptr_w = $clog2(PRE_DEPTH);

  logic [acq_pkg::sample_w:0] hist [PRE_DEPTH];  // {ovr, sample}
  logic [ptr_w-1:0]           wr_ptr;
  logic [ptr_w-1:0]           rd_ptr;
  logic [ptr_w-1:0]           rd_addr;           // history read address
  logic [acq_pkg::sample_w:0] hist_q;            // registered history read
  logic [acq_pkg::sample_w:0] rd_q;              // history read, one stage later
  logic                       rd_vld;
  logic [13:0]                rd_left;           // samples still to read
  logic [2:0]                 lane_idx;
  logic [10:0]                words_left;        // data words still to emit
  logic                       hdr_pend;
  logic                       ovr_acc;
  logic                       emit_data;
  logic                       emit_hdr;
  logic                       cap_busy;
  logic [acq_pkg::samples_per_burst-1:0][15:0] lanes;
  logic [acq_pkg::samples_per_burst-1:0][15:0] lanes_nxt;

  //////////////////////////////
  // sample history

  always_ff @(posedge clk125) begin
    hist[wr_ptr] <= {adc_ovr, adc_dat};
    hist_q       <= hist[rd_addr];  // old contents if the slot is written on this edge
    rd_q         <= hist_q;
  end

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr + 1'b1;  // free running, wraps at PRE_DEPTH
    end
  end

  // sample 0 is read in the cap_start cycle, before its slot comes round again
  assign rd_addr = cap_start ? wr_ptr - ptr_w'(cap_cfg.pre_trig) - 1'b1 : rd_ptr;

  // read side trails the write side by pre_trig + 1
  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr  <= '0;
      rd_left <= '0;
      rd_vld  <= 1'b0;
    end else if (cap_start) begin
      rd_ptr  <= wr_ptr - ptr_w'(cap_cfg.pre_trig);  // sample 1 on the next edge
      rd_left <= {cap_cfg.num_bursts, 3'b000};
      rd_vld  <= 1'b0;
    end else begin
      rd_vld <= (rd_left != '0);
      if (rd_left != '0) begin
        rd_ptr  <= rd_ptr + 1'b1;
        rd_left <= rd_left - 1'b1;
      end
    end
  end

  //////////////////////////////
  // burst packing

  assign lanes_nxt = {16'(rd_q[acq_pkg::sample_w-1:0]),
                      lanes[acq_pkg::samples_per_burst-1:1]};  // first sample ends in lane 0
  assign emit_data = rd_vld && (lane_idx == 3'd7);
  assign emit_hdr  = !rd_vld && hdr_pend;                       // cycle after the last data word
  assign cap_busy  = (words_left != '0) || hdr_pend;

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      lane_idx       <= '0;
      words_left     <= '0;
      hdr_pend       <= 1'b0;
      ovr_acc        <= 1'b0;
      cap_word_valid <= 1'b0;
    end else begin
      cap_word_valid <= emit_data || emit_hdr;
      if (cap_start) begin
        lane_idx   <= '0;
        words_left <= cap_cfg.num_bursts;
        ovr_acc    <= 1'b0;
      end else if (rd_vld) begin
        lane_idx <= lane_idx + 1'b1;
        ovr_acc  <= ovr_acc | rd_q[acq_pkg::sample_w];
        if (emit_data) begin
          words_left <= words_left - 1'b1;
          hdr_pend   <= (words_left == 11'd1);
        end
      end else if (emit_hdr) begin
        hdr_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk125) begin
    if (rd_vld) begin
      lanes <= lanes_nxt;
    end
    if (emit_data) begin
      cap_word.tag             <= acq_pkg::tag_data;
      cap_word.payload.samples <= lanes_nxt;
    end else if (emit_hdr) begin
      cap_word.tag                        <= acq_pkg::tag_header;
      cap_word.payload.header.fill_num    <= cap_cfg.fill_num;
      cap_word.payload.header.channel_tag <= cap_cfg.channel_tag;
      cap_word.payload.header.fill_type   <= cap_cfg.fill_type;
      cap_word.payload.header.num_bursts  <= cap_cfg.num_bursts;
      cap_word.payload.header.pre_trig    <= cap_cfg.pre_trig;
      cap_word.payload.header.ovr_seen    <= ovr_acc;  // includes the last burst
      cap_word.payload.header.pad         <= '0;
    end
  end

  // the history must reach back to the first sample of the fill
  assert property (@(posedge clk125) disable iff (!rst_n)
    cap_start |-> (cap_cfg.pre_trig < PRE_DEPTH))
    else $error("pre-trigger length exceeds the sample history");

  // trigger control holds off until the previous fill is stored
  assert property (@(posedge clk125) disable iff (!rst_n) cap_start |-> !cap_busy)
    else $error("capture restarted while a fill is still running");

endmodule

`default_nettype wire

// File: hdl/acq_pkg.sv
`default_nettype none

package acq_pkg;

  //////////////////////////////
  // widths

  localparam int sample_w          = 12;  // one adc sample
  localparam int samples_per_burst = 8;   // samples packed into one memory word
  localparam int fill_num_w        = 24;  // fill counter
  localparam int addr_w            = 23;  // host side word address

  // tag carried in the top 4 bits of every stored word
  typedef enum logic [3:0] {
    tag_data   = 4'h0,  // eight samples
    tag_header = 4'h1   // fill header, lands at the fill base
  } word_tag_t;

  // header layout inside the 128-bit payload
  typedef struct packed {
    logic [fill_num_w-1:0] fill_num;     // consecutive fill number
    logic [15:0]           channel_tag;  // host supplied channel info
    logic [1:0]            fill_type;    // {enable1, enable0} at the trigger
    logic [10:0]           num_bursts;   // data words in this fill
    logic [11:0]           pre_trig;     // samples ahead of the trigger sample
    logic                  ovr_seen;     // over-range on any sample of the fill
    logic [61:0]           pad;          // zero
  } hdr_view_t;

  //////////////////////////////
  // memory word

  typedef union packed {
    logic [samples_per_burst-1:0][15:0] samples;  // lane j holds sample 8b+j, zero-extended
    hdr_view_t                          header;
  } mem_payload_u;

  typedef struct packed {
    word_tag_t    tag;
    mem_payload_u payload;
  } mem_word_t;  // 132 bits

  //////////////////////////////
  // per fill records

  // latched by the trigger control at the accepting edge
  typedef struct packed {
    logic [fill_num_w-1:0] fill_num;
    logic [15:0]           channel_tag;
    logic [1:0]            fill_type;
    logic [10:0]           num_bursts;
    logic [11:0]           pre_trig;
  } fill_cfg_t;

  // one entry of the header fifo, 72 bits
  typedef struct packed {
    logic [fill_num_w-1:0] fill_num;
    logic [addr_w-1:0]     start_addr;  // address of the header word
    logic [24:0]           word_cnt;    // num_bursts + 1
  } fill_rec_t;

endpackage

`default_nettype wire

// File: hdl/acq_trigger_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module acq_trigger_ctrl (
  input  wire                           clk125,
  input  wire                           rst_n,
  input  wire                           acq_trig,             // from master, starts a fill
  input  wire                           acq_enable0,          // enable, fill type bit 0
  input  wire                           acq_enable1,          // enable, fill type bit 1
  input  wire [15:0]                    channel_tag,
  input  wire [acq_pkg::fill_num_w-1:0] initial_fill_num,
  input  wire                           initial_fill_num_wr,  // load strobe
  input  wire [10:0]                    async_num_bursts,
  input  wire [11:0]                    async_pre_trig,
  input  wire                           fill_written,         // header record is queued
  input  wire                           hdr_fifo_full,
  output logic                          cap_start,
  output acq_pkg::fill_cfg_t            cap_cfg,
  output logic                          acq_done,
  output logic                          adc_acq_sm_idle,
  output logic                          acq_enabled
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t                         state;
  logic [1:0]                     fill_type;
  logic                           trig_ok;        // trigger accepted on this edge
  logic [acq_pkg::fill_num_w-1:0] next_fill_num;  // number for the next accepted fill

  assign fill_type       = {acq_enable1, acq_enable0};
  assign acq_enabled     = (fill_type != 2'b00) && !hdr_fifo_full;
  assign adc_acq_sm_idle = (state == st_idle);
  assign trig_ok         = acq_trig && (state == st_idle) && acq_enabled &&
                           (async_num_bursts != 11'd0);

  //////////////////////////////
  // one fill at a time

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      cap_start <= 1'b0;
      acq_done  <= 1'b0;
    end else begin
      cap_start <= trig_ok;  // capture starts one cycle after the accepting edge
      acq_done  <= 1'b0;
      case (state)
        st_idle: begin
          if (trig_ok) begin
            state <= st_busy;
          end
        end
        st_busy: begin
          if (fill_written) begin  // busy until the store has the record
            state    <= st_idle;
            acq_done <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // fill numbering, a load wins over the increment
  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      next_fill_num <= '0;
    end else if (initial_fill_num_wr) begin
      next_fill_num <= initial_fill_num;
    end else if (trig_ok) begin
      next_fill_num <= next_fill_num + 1'b1;
    end
  end

  // config snapshot, held until the next trigger
  always_ff @(posedge clk125) begin
    if (trig_ok) begin
      cap_cfg.fill_num    <= next_fill_num;
      cap_cfg.channel_tag <= channel_tag;
      cap_cfg.fill_type   <= fill_type;
      cap_cfg.num_bursts  <= async_num_bursts;
      cap_cfg.pre_trig    <= async_pre_trig;
    end
  end

endmodule

`default_nettype wire

// File: hdl/adc_acq_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_acq_mem_top #(
  parameter int PRE_DEPTH = 4096,
  parameter int MEM_WORDS = 4096,
  parameter int HDR_DEPTH = 4
) (
  input  wire                           clk125,
  input  wire                           rst_n,
  input  wire                           acq_trig,             // from master
  input  wire                           acq_enable0,
  input  wire                           acq_enable1,
  output logic                          acq_done,             // to master, end of fill
  output logic                          adc_acq_sm_idle,
  output logic                          acq_enabled,
  input  wire [15:0]                    channel_tag,
  input  wire [acq_pkg::fill_num_w-1:0] initial_fill_num,
  input  wire                           initial_fill_num_wr,
  input  wire [10:0]                    async_num_bursts,
  input  wire [11:0]                    async_pre_trig,
  input  wire [acq_pkg::sample_w-1:0]   adc_dat,
  input  wire                           adc_ovr,
  output logic                          fill_header_fifo_empty,
  input  wire                           fill_header_fifo_rd_en,
  output acq_pkg::fill_rec_t            fill_header_fifo_out,
  input  wire [acq_pkg::addr_w-1:0]     ddr3_rd_start_addr,
  input  wire [23:0]                    ddr3_rd_burst_cnt,
  input  wire                           enable_reading,
  output logic                          reading_done,
  output logic                          ddr3_rd_fifo_wr_en,
  output acq_pkg::mem_word_t            ddr3_rd_fifo_input_dat,
  input  wire                           ddr3_rd_fifo_almost_full,
  output logic                          ddr3_rd_fifo_input_tlast
);

  logic               cap_start;       // trigger control to capture
  acq_pkg::fill_cfg_t cap_cfg;
  logic               cap_word_valid;  // capture to store
  acq_pkg::mem_word_t cap_word;
  logic               fill_written;    // store to trigger control
  logic               hdr_fifo_full;

  acq_trigger_ctrl u_trigger_ctrl (.*);

  acq_capture #(.PRE_DEPTH(PRE_DEPTH)) u_capture (.*);

  wave_store #(.MEM_WORDS(MEM_WORDS), .HDR_DEPTH(HDR_DEPTH)) u_store (.*);

endmodule

`default_nettype wire

// File: hdl/wave_store.sv
`timescale 1ns/1ps
`default_nettype none

module wave_store #(
  parameter int MEM_WORDS = 4096,
  parameter int HDR_DEPTH = 4
) (
  input  wire                         clk125,
  input  wire                         rst_n,
  input  wire                         cap_word_valid,
  input  wire acq_pkg::mem_word_t     cap_word,
  output logic                        fill_written,            // record entered the fifo
  output logic                        hdr_fifo_full,
  output logic                        fill_header_fifo_empty,  // record at head when low
  input  wire                         fill_header_fifo_rd_en,  // pops the head
  output acq_pkg::fill_rec_t          fill_header_fifo_out,
  input  wire [acq_pkg::addr_w-1:0]   ddr3_rd_start_addr,      // first word to read
  input  wire [23:0]                  ddr3_rd_burst_cnt,       // words to read
  input  wire                         enable_reading,          // loads and starts the engine
  output logic                        reading_done,
  output logic                        ddr3_rd_fifo_wr_en,
  output acq_pkg::mem_word_t          ddr3_rd_fifo_input_dat,
  input  wire                         ddr3_rd_fifo_almost_full,
  output logic                        ddr3_rd_fifo_input_tlast
);

  localparam int aw   = $clog2(MEM_WORDS);
  localparam int hp_w = (HDR_DEPTH > 1) ? $clog2(HDR_DEPTH) : 1;
  localparam int hc_w = $clog2(HDR_DEPTH + 1);

  acq_pkg::mem_word_t mem [MEM_WORDS];
  logic [aw-1:0]      base;      // header address of the fill being written
  logic [10:0]        data_cnt;  // data words written so far in this fill
  logic [aw-1:0]      wr_addr;
  logic               is_hdr;
  logic               push;
  logic               pop;
  acq_pkg::fill_rec_t rec_in;
  acq_pkg::fill_rec_t hdr_fifo [HDR_DEPTH];
  logic [hp_w-1:0]    hf_wr_ptr;
  logic [hp_w-1:0]    hf_rd_ptr;
  logic [hc_w-1:0]    hf_count;
  logic [aw-1:0]      rd_addr;
  logic [23:0]        rd_left;   // words not yet issued
  logic               issue;

  //////////////////////////////
  // write side

  assign is_hdr  = (cap_word.tag == acq_pkg::tag_header);
  assign wr_addr = is_hdr ? base : base + aw'(data_cnt) + 1'b1;  // data from base+1 up
  assign push    = cap_word_valid && is_hdr;

  assign rec_in.fill_num   = cap_word.payload.header.fill_num;
  assign rec_in.start_addr = acq_pkg::addr_w'(base);
  assign rec_in.word_cnt   = 25'(data_cnt) + 25'd1;

  always_ff @(posedge clk125) begin
    if (cap_word_valid) begin
      mem[wr_addr] <= cap_word;
    end
    ddr3_rd_fifo_input_dat <= mem[rd_addr];  // one cycle behind the address
  end

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      base         <= '0;
      data_cnt     <= '0;
      fill_written <= 1'b0;
    end else begin
      fill_written <= push;
      if (cap_word_valid) begin
        if (is_hdr) begin
          base     <= base + aw'(rec_in.word_cnt);  // next fill packs right behind
          data_cnt <= '0;
        end else begin
          data_cnt <= data_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // fill header fifo

  assign pop                    = fill_header_fifo_rd_en && !fill_header_fifo_empty;
  assign fill_header_fifo_empty = (hf_count == '0);
  assign hdr_fifo_full          = (hf_count == hc_w'(HDR_DEPTH));
  assign fill_header_fifo_out   = hdr_fifo[hf_rd_ptr];

  always_ff @(posedge clk125) begin
    if (push) begin
      hdr_fifo[hf_wr_ptr] <= rec_in;
    end
  end

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      hf_wr_ptr <= '0;
      hf_rd_ptr <= '0;
      hf_count  <= '0;
    end else begin
      if (push) begin
        hf_wr_ptr <= (hf_wr_ptr == hp_w'(HDR_DEPTH - 1)) ? '0 : hf_wr_ptr + 1'b1;
      end
      if (pop) begin
        hf_rd_ptr <= (hf_rd_ptr == hp_w'(HDR_DEPTH - 1)) ? '0 : hf_rd_ptr + 1'b1;
      end
      hf_count <= hf_count + hc_w'(push) - hc_w'(pop);
    end
  end

  //////////////////////////////
  // read engine

  assign issue = !reading_done && (rd_left != '0) && !ddr3_rd_fifo_almost_full;

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr                  <= '0;
      rd_left                  <= '0;
      reading_done             <= 1'b1;
      ddr3_rd_fifo_wr_en       <= 1'b0;
      ddr3_rd_fifo_input_tlast <= 1'b0;
    end else begin
      ddr3_rd_fifo_wr_en       <= issue;
      ddr3_rd_fifo_input_tlast <= issue && (rd_left == 24'd1);
      if (enable_reading) begin
        rd_addr      <= aw'(ddr3_rd_start_addr);
        rd_left      <= ddr3_rd_burst_cnt;
        reading_done <= (ddr3_rd_burst_cnt == '0);
      end else begin
        if (issue) begin
          rd_addr <= rd_addr + 1'b1;  // wraps with the store
          rd_left <= rd_left - 1'b1;
        end
        if (ddr3_rd_fifo_input_tlast) begin
          reading_done <= 1'b1;  // cycle after the last word
        end
      end
    end
  end

  // trigger control stops accepting fills once the fifo fills up
  assert property (@(posedge clk125) disable iff (!rst_n) push |-> !hdr_fifo_full)
    else $error("fill header pushed into a full FIFO");

  assert property (@(posedge clk125) disable iff (!rst_n)
    fill_header_fifo_rd_en |-> !fill_header_fifo_empty)
    else $error("fill header popped from an empty FIFO");

endmodule

`default_nettype wire

// File: tb/adc_acq_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc_acq_mem_tb;

  localparam int pre_depth = 256;
  localparam int mem_words = 512;
  localparam int hdr_depth = 4;
  localparam int num_rows  = 7;
  localparam int log_len   = 1 << 16;  // sample log, indexed by rising edge count

  typedef struct packed {
    logic [1:0]  en;        // {enable1, enable0}
    logic [15:0] chan;
    logic [10:0] nb;        // bursts per fill
    logic [11:0] pre;       // pre-trigger samples
    logic        load;      // load the fill number before the trigger
    logic [23:0] load_val;
    logic [15:0] stall;     // almost-full pattern, one bit per cycle
  } row_t;

  localparam row_t full_row = '{2'b01, 16'h0f0f, 11'd1, 12'd3, 1'b0, 24'h0, 16'h0};

  logic                           clk125 = 1'b0;
  logic                           rst_n;
  logic                           acq_trig, acq_enable0, acq_enable1;
  logic                           acq_done, adc_acq_sm_idle, acq_enabled;
  logic [15:0]                    channel_tag;
  logic [acq_pkg::fill_num_w-1:0] initial_fill_num;
  logic                           initial_fill_num_wr;
  logic [10:0]                    async_num_bursts;
  logic [11:0]                    async_pre_trig;
  logic [acq_pkg::sample_w-1:0]   adc_dat;
  logic                           adc_ovr;
  logic                           fill_header_fifo_empty, fill_header_fifo_rd_en;
  acq_pkg::fill_rec_t             fill_header_fifo_out;
  logic [acq_pkg::addr_w-1:0]     ddr3_rd_start_addr;
  logic [23:0]                    ddr3_rd_burst_cnt;
  logic                           enable_reading, reading_done;
  logic                           ddr3_rd_fifo_wr_en, ddr3_rd_fifo_almost_full;
  acq_pkg::mem_word_t             ddr3_rd_fifo_input_dat;
  logic                           ddr3_rd_fifo_input_tlast;

  int                 edge_cnt = 0;             // index of the next rising edge
  logic [11:0]        samp_log [log_len];
  logic               ovr_log [log_len];
  acq_pkg::mem_word_t exp_words [$];            // last fill, header first
  acq_pkg::fill_rec_t exp_recs [$];             // records still in the fifo
  logic [8:0]         exp_base = '0;            // wraps with mem_words
  logic [23:0]        exp_num = '0;
  row_t               rows [num_rows];
  string              names [num_rows];

  adc_acq_mem_top #(
    .PRE_DEPTH(pre_depth),
    .MEM_WORDS(mem_words),
    .HDR_DEPTH(hdr_depth)
  ) u_dut (.*);

  always #50 clk125 = ~clk125;  // 100 ns period

  //////////////////////////////
  // adc source and sample log

  initial begin
    void'($urandom(32'hd7b4_06a1));
    adc_dat = '0;
    adc_ovr = 1'b0;
    forever begin
      @(negedge clk125);
      adc_dat = adc_dat + 1'b1;           // free running ramp
      adc_ovr = ($urandom % 32) == 0;     // rare over-range
    end
  end

  always @(posedge clk125) begin
    samp_log[edge_cnt % log_len] <= adc_dat;
    ovr_log[edge_cnt % log_len]  <= adc_ovr;
    edge_cnt                     <= edge_cnt + 1;
  end

  //////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [131:0] exp,
                             input logic [131:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  task automatic fail_now(input string what);
    $display("Testbench failed");
    $fatal(1, "%s", what);
  endtask

  task automatic drive_trigger(input row_t r, output int trig_e);
    {acq_enable1, acq_enable0} = r.en;
    channel_tag      = r.chan;
    async_num_bursts = r.nb;
    async_pre_trig   = r.pre;
    acq_trig         = 1'b1;
    trig_e           = edge_cnt;  // accepting edge is the next rising one
    @(negedge clk125);
    acq_trig = 1'b0;
  endtask

  // trigger that must be ignored, watched over a fixed window
  task automatic check_rejected(input string name, input row_t r, input logic exp_empty);
    int trig_e;
    drive_trigger(r, trig_e);
    repeat (100) begin
      check_value({name, " acq_done"}, 1'b0, acq_done);
      check_value({name, " idle"}, 1'b1, adc_acq_sm_idle);
      check_value({name, " fifo empty"}, exp_empty, fill_header_fifo_empty);
      @(negedge clk125);
    end
  endtask

  task automatic run_fill(input string name, input row_t r);
    int                 trig_e, first, n, b, j;
    logic               ovr;
    acq_pkg::mem_word_t w;
    acq_pkg::fill_rec_t rec;
    drive_trigger(r, trig_e);
    n = 0;
    while (acq_done !== 1'b1) begin
      @(negedge clk125);
      n++;
      if (n > 8 * int'(r.nb) + 100) fail_now({"timeout waiting for acq_done in ", name});
    end
    rec.fill_num   = exp_num;
    rec.start_addr = 23'(exp_base);
    rec.word_cnt   = 25'(r.nb) + 25'd1;
    exp_recs.push_back(rec);
    exp_base = 9'(exp_base + r.nb + 1);      // next fill right behind this one
    exp_num  = exp_num + 1'b1;
    first    = trig_e - int'(r.pre);         // edge of sample 0
    ovr      = 1'b0;
    exp_words.delete();
    for (b = 0; b < int'(r.nb); b++) begin
      w.tag = acq_pkg::tag_data;
      for (j = 0; j < 8; j++) begin
        w.payload.samples[j] = {4'h0, samp_log[(first + 8 * b + j) % log_len]};
        ovr |= ovr_log[(first + 8 * b + j) % log_len];
      end
      exp_words.push_back(w);
    end
    w = '0;
    w.tag                        = acq_pkg::tag_header;
    w.payload.header.fill_num    = rec.fill_num;
    w.payload.header.channel_tag = r.chan;
    w.payload.header.fill_type   = r.en;
    w.payload.header.num_bursts  = r.nb;
    w.payload.header.pre_trig    = r.pre;
    w.payload.header.ovr_seen    = ovr;
    exp_words.push_front(w);                 // header sits at the base
  endtask

  task automatic pop_record(input string name, output acq_pkg::fill_rec_t rec);
    rec = exp_recs.pop_front();
    check_value({name, " fifo empty"}, 1'b0, fill_header_fifo_empty);
    check_value({name, " record"}, rec, fill_header_fifo_out);
    fill_header_fifo_rd_en = 1'b1;
    @(negedge clk125);
    fill_header_fifo_rd_en = 1'b0;
  endtask

  task automatic read_fill(input string name, input acq_pkg::fill_rec_t rec,
                           input logic [15:0] stall);
    int n, got, limit;
    n     = 0;
    got   = 0;
    limit = 20 * int'(rec.word_cnt) + 100;
    ddr3_rd_start_addr       = rec.start_addr;
    ddr3_rd_burst_cnt        = 24'(rec.word_cnt);
    ddr3_rd_fifo_almost_full = stall[0];
    enable_reading           = 1'b1;
    @(negedge clk125);
    enable_reading = 1'b0;
    while (reading_done !== 1'b1) begin
      if (ddr3_rd_fifo_wr_en === 1'b1) begin
        if (got >= exp_words.size()) fail_now({name, " read more words than stored"});
        check_value({name, " word"}, exp_words[got], ddr3_rd_fifo_input_dat);
        check_value({name, " tlast"}, got == int'(rec.word_cnt) - 1, ddr3_rd_fifo_input_tlast);
        got++;
      end else begin
        check_value({name, " tlast without word"}, 1'b0, ddr3_rd_fifo_input_tlast);
      end
      ddr3_rd_fifo_almost_full = stall[n % 16];
      @(negedge clk125);
      n++;
      if (n > limit) fail_now({"timeout waiting for reading_done in ", name});
    end
    check_value({name, " word count"}, exp_words.size(), got);
    ddr3_rd_fifo_almost_full = 1'b0;
  endtask

  //////////////////////////////
  // stimulus table and run

  initial begin
    acq_pkg::fill_rec_t rec;
    int                 i;
    rst_n = 1'b0;
    {acq_trig, acq_enable0, acq_enable1} = '0;
    channel_tag = '0;
    initial_fill_num = '0;
    initial_fill_num_wr = 1'b0;
    async_num_bursts = '0;
    async_pre_trig = '0;
    fill_header_fifo_rd_en = 1'b0;
    ddr3_rd_start_addr = '0;
    ddr3_rd_burst_cnt = '0;
    enable_reading = 1'b0;
    ddr3_rd_fifo_almost_full = 1'b0;
    //          en     chan      nb       pre      ld    load_val   stall
    rows[0] = '{2'b01, 16'h00a5, 11'd3,   12'd20,  1'b0, 24'h0,     16'h0000};
    rows[1] = '{2'b00, 16'h0001, 11'd2,   12'd4,   1'b0, 24'h0,     16'h0000};
    rows[2] = '{2'b11, 16'h0002, 11'd0,   12'd4,   1'b0, 24'h0,     16'h0000};
    rows[3] = '{2'b10, 16'h1234, 11'd5,   12'd100, 1'b1, 24'h00abc0, 16'hf0f0};
    rows[4] = '{2'b11, 16'hbeef, 11'd4,   12'd0,   1'b0, 24'h0,     16'h6db6};
    rows[5] = '{2'b01, 16'h7e57, 11'd200, 12'd255, 1'b0, 24'h0,     16'h8421};
    rows[6] = '{2'b10, 16'hc0de, 11'd300, 12'd7,   1'b0, 24'h0,     16'hfffe};  // base wraps
    names = '{"basic", "no_enable", "zero_bursts", "load_num", "after_load",
              "long_fill", "wrap_base"};
    repeat (10) @(negedge clk125);
    rst_n = 1'b1;
    repeat (300) @(negedge clk125);  // let the history cover the longest pre-trigger
    for (i = 0; i < num_rows; i++) begin
      if (rows[i].load) begin
        initial_fill_num    = rows[i].load_val;
        initial_fill_num_wr = 1'b1;
        exp_num             = rows[i].load_val;
        @(negedge clk125);
        initial_fill_num_wr = 1'b0;
      end
      if (rows[i].en == 2'b00 || rows[i].nb == 11'd0) begin
        check_rejected(names[i], rows[i], 1'b1);
      end else begin
        run_fill(names[i], rows[i]);
        pop_record(names[i], rec);
        read_fill(names[i], rec, rows[i].stall);
      end
    end
    // fill the header fifo without popping
    for (i = 0; i < hdr_depth; i++) run_fill("fifo_full", full_row);
    check_value("fifo_full acq_enabled", 1'b0, acq_enabled);
    check_rejected("fifo_full", full_row, 1'b0);
    pop_record("fifo_full", rec);
    check_value("fifo_full reenabled", 1'b1, acq_enabled);
    for (i = 1; i < hdr_depth; i++) pop_record("fifo_full", rec);
    check_value("fifo_full drained", 1'b1, fill_header_fifo_empty);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
